// ==== Makefile ====
VERILATOR ?= verilator
# decimal form of 32'hec06.
SEED ?= 60422
LOG ?= sim.log

TOP := oldland_pipe_tb
FLIST := oldland_pipe.f
SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN := obj_dir/V$(TOP)
SEED_STAMP := obj_dir/.seed_$(SEED)

.PHONY: run clean

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then exit 1; fi

$(BIN): $(SRCS) $(FLIST) $(SEED_STAMP)
	$(VERILATOR) --binary --timing --assert -j 0 -f $(FLIST) \
		--top-module $(TOP) -Gseed=$(SEED)

# a new seed leaves a new stamp, which forces a rebuild.
$(SEED_STAMP):
	mkdir -p obj_dir
	rm -f obj_dir/.seed_*
	touch $@

clean:
	rm -rf obj_dir $(LOG)

// ==== common/oldland_ctrl_pkg.sv ====
package oldland_ctrl_pkg;

	// access width of a load or store.
	typedef enum logic [1:0] {
		WIDTH_32 = 2'd0,
		WIDTH_16 = 2'd1,
		WIDTH_8  = 2'd2
	} mem_width_t;

	// where the writeback stage takes the register result from.
	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_LINK = 2'd1,
		WB_LOAD = 2'd2
	} wb_src_t;

endpackage

// ==== common/oldland_isa_pkg.sv ====
package oldland_isa_pkg;

	typedef enum logic [1:0] {
		CLASS_ALU    = 2'd0,
		CLASS_BRANCH = 2'd1,
		CLASS_MEM    = 2'd2,
		CLASS_MISC   = 2'd3
	} instr_class_t;

	// values not listed here never branch.
	typedef enum logic [2:0] {
		COND_NE     = 3'd1,
		COND_EQ     = 3'd2,
		COND_NC     = 3'd3,
		COND_C      = 3'd4,
		COND_ALWAYS = 3'd7
	} branch_cond_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_ADDC = 4'd1,
		ALU_SUB  = 4'd2,
		ALU_SUBC = 4'd3,
		ALU_LSL  = 4'd4,
		ALU_LSR  = 4'd5,
		ALU_AND  = 4'd6,
		ALU_XOR  = 4'd7,
		ALU_BIC  = 4'd8,
		ALU_BST  = 4'd9,
		ALU_OR   = 4'd10,
		ALU_MOVB = 4'd11,
		ALU_CMP  = 4'd12,
		ALU_RSVD = 4'd13,
		ALU_ASR  = 4'd14,
		ALU_MOVA = 4'd15
	} alu_opc_t;

	// the class field is called iclass since class is a keyword.
	typedef struct packed {
		instr_class_t iclass;
		logic         use_imm;
		logic [3:0]   opc;
		logic [2:0]   rd;
		logic [2:0]   ra;
		logic [2:0]   rb;
		logic [15:0]  unused;
	} instr_reg_t;

	typedef struct packed {
		instr_class_t       iclass;
		logic               use_imm;
		logic [3:0]         opc;
		logic [2:0]         rd;
		logic [2:0]         ra;
		logic signed [18:0] imm19;
	} instr_imm_t;

	typedef union packed {
		instr_reg_t reg_fmt;
		instr_imm_t imm_fmt;
	} instr_t;

endpackage

// ==== decode/oldland_decode.sv ====
`timescale 1ns/100ps

module oldland_decode
	import oldland_isa_pkg::*, oldland_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         instr_valid,
	input  instr_t       instr,
	input  logic [31:0]  pc,
	input  logic [31:0]  ra_val,
	input  logic [31:0]  rb_val,
	output logic [2:0]   ra_sel,
	output logic [2:0]   rb_sel,
	output logic [31:0]  ra,
	output logic [31:0]  rb,
	output logic [31:0]  imm32,
	output logic [31:0]  pc_plus_4,
	output logic [2:0]   rd_sel,
	output logic         update_rd,
	output alu_opc_t     alu_opc,
	output logic         alu_op1_ra,
	output logic         alu_op2_rb,
	output logic         mem_load,
	output logic         mem_store,
	output mem_width_t   mem_width,
	output branch_cond_t branch_condition,
	output instr_class_t instr_class,
	output logic         is_call,
	output logic         update_flags
);

	logic         valid;
	logic         nx_update_rd;
	logic         nx_update_flags;
	logic         nx_op1_ra;
	logic         nx_op2_rb;
	logic         nx_load;
	logic         nx_store;
	logic         nx_call;
	alu_opc_t     nx_opc;
	branch_cond_t nx_cond;
	mem_width_t   nx_width;
	logic [31:0]  nx_imm;

	assign ra_sel = instr.reg_fmt.ra;
	assign rb_sel = instr.reg_fmt.rb;
	assign nx_imm = {{13{instr.imm_fmt.imm19[18]}}, instr.imm_fmt.imm19};

	always_comb begin
		nx_update_rd = 1'b0;
		nx_update_flags = 1'b0;
		nx_op1_ra = 1'b1;
		nx_op2_rb = 1'b0;
		nx_load = 1'b0;
		nx_store = 1'b0;
		nx_call = 1'b0;
		nx_opc = ALU_ADD;
		nx_cond = branch_cond_t'(3'd0);
		nx_width = WIDTH_32;

		case (instr.reg_fmt.iclass)
		CLASS_ALU: begin
			nx_opc = alu_opc_t'(instr.reg_fmt.opc);
			nx_op2_rb = !instr.reg_fmt.use_imm;
			nx_update_rd = 1'b1;
			nx_update_flags = 1'b1;
		end
		CLASS_BRANCH: begin
			// target is pc + 4 + imm, calls link into rd.
			nx_op1_ra = 1'b0;
			nx_cond = branch_cond_t'(instr.imm_fmt.opc[2:0]);
			nx_call = instr.imm_fmt.opc[3];
			nx_update_rd = instr.imm_fmt.opc[3];
		end
		CLASS_MEM: begin
			nx_store = instr.imm_fmt.opc[0];
			nx_load = !instr.imm_fmt.opc[0];
			nx_width = mem_width_t'(instr.imm_fmt.opc[2:1]);
			nx_update_rd = !instr.imm_fmt.opc[0];
		end
		default: begin
			nx_opc = ALU_MOVB;
			nx_update_rd = 1'b1;
		end
		endcase

		// a bubble carries no side effects.
		if (!instr_valid) begin
			nx_update_rd = 1'b0;
			nx_update_flags = 1'b0;
			nx_load = 1'b0;
			nx_store = 1'b0;
			nx_call = 1'b0;
			nx_cond = branch_cond_t'(3'd0);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= 1'b0;
			update_rd <= 1'b0;
			update_flags <= 1'b0;
			mem_load <= 1'b0;
			mem_store <= 1'b0;
			is_call <= 1'b0;
			branch_condition <= branch_cond_t'(3'd0);
		end else begin
			valid <= instr_valid;
			update_rd <= nx_update_rd;
			update_flags <= nx_update_flags;
			mem_load <= nx_load;
			mem_store <= nx_store;
			is_call <= nx_call;
			branch_condition <= nx_cond;
		end
	end

	always_ff @(posedge clk) begin
		ra <= ra_val;
		rb <= rb_val;
		imm32 <= nx_imm;
		pc_plus_4 <= pc + 32'd4;
		rd_sel <= instr.reg_fmt.rd;
		alu_opc <= nx_opc;
		alu_op1_ra <= nx_op1_ra;
		alu_op2_rb <= nx_op2_rb;
		mem_width <= nx_width;
		instr_class <= instr.reg_fmt.iclass;
	end

	// without forwarding a result reaches the register file three cycles later.
	a_issue_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		valid |-> !instr_valid [*3])
		else $error("instruction issued within three cycles of the previous one");

endmodule

// ==== dv/oldland_pipe_tb.sv ====
`timescale 1ns/100ps

module oldland_pipe_tb
	import oldland_isa_pkg::*, oldland_ctrl_pkg::*;
#(
	parameter logic [31:0] seed = 32'hec06
);

	localparam int num_tests = 5;
	localparam int instrs_per_test = 64;
	localparam int clk_period = 4;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] load_data;
	logic        branch_taken;
	logic [31:0] branch_target;
	logic        mem_load;
	logic        mem_store;
	logic [1:0]  mem_width;
	logic [31:0] mar;
	logic [31:0] mdr;
	logic        wr_en;
	logic [2:0]  wr_sel;
	logic [31:0] wr_data;

	logic [31:0] rng;
	logic [31:0] model_regs [8];
	logic [31:0] mem [256];
	logic        c_flag;
	logic        z_flag;
	int          checks;
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_failed;

	oldland_pipe uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.pc            (pc),
		.load_data     (load_data),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.mem_load      (mem_load),
		.mem_store     (mem_store),
		.mem_width     (mem_width),
		.mar           (mar),
		.mdr           (mdr),
		.wr_en         (wr_en),
		.wr_sel        (wr_sel),
		.wr_data       (wr_data)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] rand32();
		rng = xorshift(rng);
		return rng;
	endfunction

	// bit 32 of the result is the carry out.
	function automatic logic [32:0] alu_model(input logic [3:0] opc, input logic [31:0] a,
			input logic [31:0] b, input logic cin);
		logic [63:0] shl;
		shl = {32'd0, a} << b[4:0];
		case (opc)
		ALU_ADD:          return {1'b0, a} + {1'b0, b};
		ALU_ADDC:         return {1'b0, a} + {1'b0, b} + {32'd0, cin};
		ALU_SUB, ALU_CMP: return {1'b0, a} - {1'b0, b};
		ALU_SUBC:         return {1'b0, a} - {1'b0, b} + {32'd0, cin};
		ALU_LSL:          return shl[32:0];
		ALU_LSR:          return {1'b0, a >> b[4:0]};
		ALU_AND:          return {1'b0, a & b};
		ALU_XOR:          return {1'b0, a ^ b};
		ALU_BIC:          return {1'b0, a & ~(32'd1 << b[4:0])};
		ALU_BST:          return {1'b0, a | (32'd1 << b[4:0])};
		ALU_OR:           return {1'b0, a | b};
		ALU_MOVB:         return {1'b0, b};
		ALU_ASR:          return {1'b0, $signed(a) >>> b[4:0]};
		ALU_MOVA:         return {1'b0, a};
		default:          return 33'd0;
		endcase
	endfunction

	function automatic logic branch_condition_met(input logic [2:0] cond);
		case (cond)
		COND_NE:     return !z_flag;
		COND_EQ:     return z_flag;
		COND_NC:     return !c_flag;
		COND_C:      return c_flag;
		COND_ALWAYS: return 1'b1;
		default:     return 1'b0;
		endcase
	endfunction

	// sub-word reads come back zero extended from their lane.
	function automatic logic [31:0] mem_read(input logic [31:0] addr, input logic [1:0] width);
		logic [31:0] w;
		w = mem[addr[9:2]];
		case (width)
		WIDTH_16: w = {16'd0, addr[1] ? w[31:16] : w[15:0]};
		WIDTH_8:  w = {24'd0, 8'(w >> {addr[1:0], 3'd0})};
		default:  w = w;
		endcase
		return w;
	endfunction

	task automatic mem_write(input logic [31:0] addr, input logic [1:0] width,
			input logic [31:0] data);
		logic [31:0] mask;
		logic [4:0]  sh;
		case (width)
		WIDTH_16: begin
			sh = {addr[1], 4'd0};
			mask = 32'h0000_ffff << sh;
		end
		WIDTH_8: begin
			sh = {addr[1:0], 3'd0};
			mask = 32'h0000_00ff << sh;
		end
		default: begin
			sh = 5'd0;
			mask = 32'hffff_ffff;
		end
		endcase
		mem[addr[9:2]] = (mem[addr[9:2]] & ~mask) | ((data << sh) & mask);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	// issue one instruction at a falling edge and follow it to retirement.
	task automatic run_instr(input logic [31:0] word, input logic [31:0] pc_val);
		logic [1:0]  cls;
		logic [3:0]  opc;
		logic [2:0]  rd;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] rbv;
		logic [31:0] res;
		logic [32:0] alu;
		logic        taken;
		logic        wr_exp;
		logic        ld_exp;
		logic        st_exp;

		cls = word[31:30];
		opc = word[28:25];
		rd = word[24:22];
		imm = {{13{word[18]}}, word[18:0]};
		a = model_regs[word[21:19]];
		rbv = model_regs[word[18:16]];
		res = imm;
		taken = 1'b0;
		wr_exp = 1'b1;
		ld_exp = (cls == CLASS_MEM) && !opc[0];
		st_exp = (cls == CLASS_MEM) && opc[0];
		case (cls)
		CLASS_ALU: begin
			alu = alu_model(opc, a, word[29] ? imm : rbv, c_flag);
			res = alu[31:0];
			z_flag = (a == (word[29] ? imm : rbv));
			c_flag = alu[32];
		end
		CLASS_BRANCH: begin
			taken = branch_condition_met(opc[2:0]);
			res = pc_val + 32'd4;
			wr_exp = opc[3];
		end
		CLASS_MEM: begin
			a = a + imm;
			wr_exp = ld_exp;
		end
		default: res = imm;
		endcase

		instr = word;
		pc = pc_val;
		instr_valid = 1'b1;
		@(negedge clk);
		// the bubble carries random bits that must have no effect.
		instr = rand32();
		pc = rand32();
		instr_valid = 1'b0;
		@(negedge clk);
		check_value("branch_taken", 32'(branch_taken), 32'(taken));
		if (taken) begin
			check_value("branch_target", branch_target, pc_val + 32'd4 + imm);
		end
		check_value("mem_load", 32'(mem_load), 32'(ld_exp));
		check_value("mem_store", 32'(mem_store), 32'(st_exp));
		if (ld_exp || st_exp) begin
			check_value("mar", mar, a);
			check_value("mem_width", 32'(mem_width), 32'(opc[2:1]));
		end
		if (st_exp) begin
			check_value("mdr", mdr, rbv);
		end
		if (ld_exp) begin
			res = mem_read(a, opc[2:1]);
		end
		if (mem_store) begin
			mem_write(mar, mem_width, mdr);
		end
		load_data = mem_load ? mem_read(mar, mem_width) : rand32();
		@(negedge clk);
		check_value("wr_en", 32'(wr_en), 32'(wr_exp));
		if (wr_exp) begin
			check_value("wr_sel", 32'(wr_sel), 32'(rd));
			check_value("wr_data", wr_data, res);
			model_regs[rd] = res;
		end
		check_value("branch_taken", 32'(branch_taken), 32'd0);
		check_value("mem_load", 32'(mem_load), 32'd0);
		check_value("mem_store", 32'(mem_store), 32'd0);
		@(negedge clk);
		check_value("wr_en", 32'(wr_en), 32'd0);
	endtask

	// add, sub or cmp on random fields.
	function automatic logic [31:0] make_flag_setter(input logic [31:0] r);
		logic [3:0]  opc;
		logic [31:0] w;
		opc = (r[31:30] == 2'd0) ? ALU_ADD : (r[31:30] == 2'd1) ? ALU_SUB : ALU_CMP;
		w = {2'b00, r[29], opc, r[24:0]};
		// about half compare a register with itself, so zero gets set.
		if (r[28]) begin
			w[29] = 1'b0;
			w[18:16] = w[21:19];
		end
		return w;
	endfunction

	initial begin
		logic [31:0] r;
		logic [31:0] word;
		logic [31:0] prev_word;

		rng = seed;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = 32'd0;
		pc = 32'd0;
		load_data = 32'd0;
		c_flag = 1'b0;
		z_flag = 1'b0;
		checks = 0;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		prev_word = 32'd0;
		for (int i = 0; i < 8; i++) begin
			model_regs[i] = 32'd0;
		end
		for (logic [8:0] i = 9'd0; i < 9'd256; i++) begin
			mem[i[7:0]] = (32'(i) * 32'h9e37_79b1) ^ {i[7:0], 24'h00a5c3};
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		repeat (16) begin
			check_value("branch_taken", 32'(branch_taken), 32'd0);
			check_value("mem_load", 32'(mem_load), 32'd0);
			check_value("mem_store", 32'(mem_store), 32'd0);
			check_value("wr_en", 32'(wr_en), 32'd0);
			@(negedge clk);
		end
		finish_test("reset");

		for (int i = 0; i < instrs_per_test; i++) begin
			r = rand32();
			run_instr({2'b00, r[29:0]}, {rand32() & 32'hffff_fffc});
		end
		finish_test("alu");

		for (int i = 0; i < instrs_per_test / 2; i++) begin
			run_instr(make_flag_setter(rand32()), 32'd0);
			r = rand32();
			run_instr({2'b00, r[29], r[30] ? ALU_SUBC : ALU_ADDC, r[24:0]}, 32'd0);
		end
		finish_test("flags");

		// the condition walks through all eight codes.
		for (int i = 0; i < instrs_per_test / 2; i++) begin
			run_instr(make_flag_setter(rand32()), 32'd0);
			r = rand32();
			run_instr({2'b01, r[29], r[28], i[2:0], r[24:0]}, rand32() & 32'hffff_fffc);
		end
		finish_test("branch");

		// odd steps repeat the last address with the direction flipped.
		for (int i = 0; i < instrs_per_test; i++) begin
			r = rand32();
			word = {2'b10, r[29:0]};
			if (i[0]) begin
				word = prev_word;
				word[25] = ~prev_word[25];
			end
			if (word[27:26] == 2'b11) begin
				word[27:26] = 2'b00;
			end
			prev_word = word;
			run_instr(word, 32'd0);
		end
		finish_test("memory");

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, total_errors);
		if (total_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		#((num_tests * instrs_per_test * 4 + 100) * clk_period);
		$display("timeout: the tests did not complete in the allowed time");
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== exec/oldland_exec.sv ====
`timescale 1ns/100ps

module oldland_exec
	import oldland_isa_pkg::*, oldland_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic [31:0]  ra,
	input  logic [31:0]  rb,
	input  logic [31:0]  imm32,
	input  logic [31:0]  pc_plus_4,
	input  logic [2:0]   rd_sel,
	input  logic         update_rd,
	input  alu_opc_t     alu_opc,
	input  logic         alu_op1_ra,
	input  logic         alu_op2_rb,
	input  logic         mem_load,
	input  logic         mem_store,
	input  mem_width_t   mem_width,
	input  branch_cond_t branch_condition,
	input  instr_class_t instr_class,
	input  logic         is_call,
	input  logic         update_flags,
	output logic [31:0]  alu_out,
	output wb_src_t      wb_src,
	output logic [31:0]  wr_val,
	output logic         wr_result,
	output logic [2:0]   rd_sel_out,
	output logic         branch_taken,
	output logic         mem_load_out,
	output logic         mem_store_out,
	output mem_width_t   mem_width_out,
	output logic [31:0]  mar,
	output logic [31:0]  mdr
);

	logic [31:0] op1;
	logic [31:0] op2;
	logic [31:0] alu_q;
	logic        alu_c;
	logic        alu_z;
	logic        cond_met;
	logic        c_flag;
	logic        z_flag;

	assign op1 = alu_op1_ra ? ra : pc_plus_4;
	assign op2 = alu_op2_rb ? rb : imm32;
	assign alu_z = (op1 == op2);

	always_comb begin
		alu_c = 1'b0;
		alu_q = 32'd0;

		case (alu_opc)
		ALU_ADD:  {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2};
		ALU_ADDC: {alu_c, alu_q} = {1'b0, op1} + {1'b0, op2} + {32'd0, c_flag};
		ALU_SUB:  {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		ALU_SUBC: {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2} + {32'd0, c_flag};
		ALU_LSL:  {alu_c, alu_q} = {1'b0, op1} << op2[4:0];
		ALU_LSR:  alu_q = op1 >> op2[4:0];
		ALU_AND:  alu_q = op1 & op2;
		ALU_XOR:  alu_q = op1 ^ op2;
		ALU_BIC:  alu_q = op1 & ~(32'd1 << op2[4:0]);
		ALU_BST:  alu_q = op1 | (32'd1 << op2[4:0]);
		ALU_OR:   alu_q = op1 | op2;
		ALU_MOVB: alu_q = op2;
		ALU_CMP:  {alu_c, alu_q} = {1'b0, op1} - {1'b0, op2};
		ALU_ASR:  alu_q = $signed(op1) >>> op2[4:0];
		ALU_MOVA: alu_q = op1;
		default:  alu_q = 32'd0;
		endcase
	end

	// conditions test the flags left by the last flag setting instruction.
	always_comb begin
		case (branch_condition)
		COND_ALWAYS: cond_met = 1'b1;
		COND_NE:     cond_met = !z_flag;
		COND_EQ:     cond_met = z_flag;
		COND_NC:     cond_met = !c_flag;
		COND_C:      cond_met = c_flag;
		default:     cond_met = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			branch_taken <= 1'b0;
			mem_load_out <= 1'b0;
			mem_store_out <= 1'b0;
			wr_result <= 1'b0;
			c_flag <= 1'b0;
			z_flag <= 1'b0;
		end else begin
			branch_taken <= (instr_class == CLASS_BRANCH) && cond_met;
			mem_load_out <= mem_load;
			mem_store_out <= mem_store;
			wr_result <= update_rd;
			if (update_flags) begin
				c_flag <= alu_c;
				z_flag <= alu_z;
			end
		end
	end

	always_ff @(posedge clk) begin
		alu_out <= alu_q;
		rd_sel_out <= rd_sel;
		wr_val <= is_call ? pc_plus_4 : alu_q;
		if (is_call) begin
			wb_src <= WB_LINK;
		end else if (mem_load) begin
			wb_src <= WB_LOAD;
		end else begin
			wb_src <= WB_ALU;
		end
		if (mem_load || mem_store) begin
			mem_width_out <= mem_width;
			mar <= alu_q;
			if (mem_store) begin
				mdr <= rb;
			end
		end
	end

	a_mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_load_out && mem_store_out))
		else $error("load and store requested together");

endmodule

// ==== oldland_pipe.f ====
common/oldland_isa_pkg.sv
common/oldland_ctrl_pkg.sv
source/oldland_regfile.sv
decode/oldland_decode.sv
exec/oldland_exec.sv
source/oldland_writeback.sv
source/oldland_pipe.sv
dv/oldland_pipe_tb.sv

// ==== source/oldland_pipe.sv ====
`timescale 1ns/100ps

module oldland_pipe
	import oldland_isa_pkg::*, oldland_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        instr_valid,
	input  instr_t      instr,
	input  logic [31:0] pc,
	input  logic [31:0] load_data,
	output logic        branch_taken,
	output logic [31:0] branch_target,
	output logic        mem_load,
	output logic        mem_store,
	output mem_width_t  mem_width,
	output logic [31:0] mar,
	output logic [31:0] mdr,
	output logic        wr_en,
	output logic [2:0]  wr_sel,
	output logic [31:0] wr_data
);

	logic [2:0]   rf_ra_sel;
	logic [2:0]   rf_rb_sel;
	logic [31:0]  rf_ra_val;
	logic [31:0]  rf_rb_val;

	logic [31:0]  dec_ra;
	logic [31:0]  dec_rb;
	logic [31:0]  dec_imm32;
	logic [31:0]  dec_pc_plus_4;
	logic [2:0]   dec_rd_sel;
	logic         dec_update_rd;
	alu_opc_t     dec_alu_opc;
	logic         dec_alu_op1_ra;
	logic         dec_alu_op2_rb;
	logic         dec_mem_load;
	logic         dec_mem_store;
	mem_width_t   dec_mem_width;
	branch_cond_t dec_branch_condition;
	instr_class_t dec_instr_class;
	logic         dec_is_call;
	logic         dec_update_flags;

	wb_src_t      ex_wb_src;
	logic [31:0]  ex_wr_val;
	logic         ex_wr_result;
	logic [2:0]   ex_rd_sel;

	oldland_decode u_decode (
		.clk              (clk),
		.rst_n            (rst_n),
		.instr_valid      (instr_valid),
		.instr            (instr),
		.pc               (pc),
		.ra_val           (rf_ra_val),
		.rb_val           (rf_rb_val),
		.ra_sel           (rf_ra_sel),
		.rb_sel           (rf_rb_sel),
		.ra               (dec_ra),
		.rb               (dec_rb),
		.imm32            (dec_imm32),
		.pc_plus_4        (dec_pc_plus_4),
		.rd_sel           (dec_rd_sel),
		.update_rd        (dec_update_rd),
		.alu_opc          (dec_alu_opc),
		.alu_op1_ra       (dec_alu_op1_ra),
		.alu_op2_rb       (dec_alu_op2_rb),
		.mem_load         (dec_mem_load),
		.mem_store        (dec_mem_store),
		.mem_width        (dec_mem_width),
		.branch_condition (dec_branch_condition),
		.instr_class      (dec_instr_class),
		.is_call          (dec_is_call),
		.update_flags     (dec_update_flags)
	);

	oldland_regfile u_regfile (
		.clk     (clk),
		.ra_sel  (rf_ra_sel),
		.rb_sel  (rf_rb_sel),
		.wr_en   (wr_en),
		.wr_sel  (wr_sel),
		.wr_data (wr_data),
		.ra_val  (rf_ra_val),
		.rb_val  (rf_rb_val)
	);

	// the alu result doubles as the branch target.
	oldland_exec u_exec (
		.clk              (clk),
		.rst_n            (rst_n),
		.ra               (dec_ra),
		.rb               (dec_rb),
		.imm32            (dec_imm32),
		.pc_plus_4        (dec_pc_plus_4),
		.rd_sel           (dec_rd_sel),
		.update_rd        (dec_update_rd),
		.alu_opc          (dec_alu_opc),
		.alu_op1_ra       (dec_alu_op1_ra),
		.alu_op2_rb       (dec_alu_op2_rb),
		.mem_load         (dec_mem_load),
		.mem_store        (dec_mem_store),
		.mem_width        (dec_mem_width),
		.branch_condition (dec_branch_condition),
		.instr_class      (dec_instr_class),
		.is_call          (dec_is_call),
		.update_flags     (dec_update_flags),
		.alu_out          (branch_target),
		.wb_src           (ex_wb_src),
		.wr_val           (ex_wr_val),
		.wr_result        (ex_wr_result),
		.rd_sel_out       (ex_rd_sel),
		.branch_taken     (branch_taken),
		.mem_load_out     (mem_load),
		.mem_store_out    (mem_store),
		.mem_width_out    (mem_width),
		.mar              (mar),
		.mdr              (mdr)
	);

	oldland_writeback u_writeback (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_result  (ex_wr_result),
		.rd_sel_out (ex_rd_sel),
		.wb_src     (ex_wb_src),
		.wr_val     (ex_wr_val),
		.load_data  (load_data),
		.wr_en      (wr_en),
		.wr_sel     (wr_sel),
		.wr_data    (wr_data)
	);

endmodule

// ==== source/oldland_regfile.sv ====
`timescale 1ns/100ps

module oldland_regfile (
	input  logic        clk,
	input  logic [2:0]  ra_sel,
	input  logic [2:0]  rb_sel,
	input  logic        wr_en,
	input  logic [2:0]  wr_sel,
	input  logic [31:0] wr_data,
	output logic [31:0] ra_val,
	output logic [31:0] rb_val
);

	logic [31:0] regs [8] = '{default: 32'd0};

	// reads are combinational so decode samples them with the instruction.
	assign ra_val = regs[ra_sel];
	assign rb_val = regs[rb_sel];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

// ==== source/oldland_writeback.sv ====
`timescale 1ns/100ps

module oldland_writeback
	import oldland_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        wr_result,
	input  logic [2:0]  rd_sel_out,
	input  wb_src_t     wb_src,
	input  logic [31:0] wr_val,
	input  logic [31:0] load_data,
	output logic        wr_en,
	output logic [2:0]  wr_sel,
	output logic [31:0] wr_data
);

	logic [31:0] result;

	// link and alu results both arrive through wr_val.
	assign result = (wb_src == WB_LOAD) ? load_data : wr_val;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_en <= 1'b0;
		end else begin
			wr_en <= wr_result;
		end
	end

	always_ff @(posedge clk) begin
		wr_sel <= rd_sel_out;
		wr_data <= result;
	end

	a_wr_sel_known: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !$isunknown(wr_sel))
		else $error("register write with unknown destination");

endmodule
